// ==== list.f ====
logic/aip_cfg_pkg.sv
logic/aip_data_pkg.sv
logic/aip_coeff_regs.sv
logic/aip_sample_bank.sv
logic/aip_scan_ctrl.sv
logic/aip_mac_unit.sv
logic/aip_top.sv
testbench/aip_chk.sv
testbench/aip_tb.sv

// ==== logic/aip_cfg_pkg.sv ====
// Register map and bus types; word addressed, full 32-bit accesses only, no byte select
package aip_cfg_pkg;

    // Word address width of the register space
    localparam int ADDR_W = 5;

    // Control word, then 24 coefficients at REG_COEFF_BASE + chn*4 + kind
    // Kind order is ke, b, kqe, bq
    localparam logic [ADDR_W-1:0] REG_CTRL       = 5'd0;
    localparam logic [ADDR_W-1:0] REG_COEFF_BASE = 5'd8;

    // Wishbone classic master request
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [31:0]       dat;
    } wb_req_t;

    // Wishbone classic slave response
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Scan control fields, bit 24 down to bit 0 of the control word
    typedef struct packed {
        logic        run;
        logic [11:0] period_us;
        logic [5:0]  diag_mode;
        logic [5:0]  chn_enable;
    } scan_cfg_t;

    typedef struct packed {
        logic [6:0] rsvd;
        scan_cfg_t  cfg;
    } reg_ctl_t;

    // One bus word, seen as a coefficient or as the control word
    typedef union packed {
        logic signed [31:0] coeff;
        reg_ctl_t           ctl;
    } reg_word_u;

endpackage

// ==== logic/aip_coeff_regs.sv ====
// Wishbone classic slave, one wait state per access; unmapped reads return zero, writes are dropped
`timescale 1ns/1ps

module aip_coeff_regs (
    input  logic                     clk_sys,
    input  logic                     rst_sys_n,
    input  aip_cfg_pkg::wb_req_t     wb_req,
    output aip_cfg_pkg::wb_rsp_t     wb_rsp,
    input  aip_data_pkg::chn_idx_t   chn_sel,
    output aip_cfg_pkg::scan_cfg_t   cfg,
    output aip_data_pkg::chn_coeff_t coeff_set
);

    aip_cfg_pkg::scan_cfg_t  cfg_q;
    aip_data_pkg::coeff_t    coeff_q [aip_data_pkg::NUM_CHN*4];
    aip_cfg_pkg::reg_word_u  wr_word;
    aip_cfg_pkg::reg_word_u  rd_word;
    logic                    ack_q;
    logic [31:0]             rd_q;
    logic                    access;
    logic                    coeff_hit;
    logic [aip_cfg_pkg::ADDR_W-1:0] coeff_idx;

    //------------------------------------------------------------
    // Address decode
    //------------------------------------------------------------
    assign access    = wb_req.cyc && wb_req.stb && !ack_q;
    assign coeff_hit = (wb_req.adr >= aip_cfg_pkg::REG_COEFF_BASE);
    assign coeff_idx = wb_req.adr - aip_cfg_pkg::REG_COEFF_BASE;
    assign wr_word   = wb_req.dat;

    always_comb begin
        rd_word = '0;
        if (wb_req.adr == aip_cfg_pkg::REG_CTRL) begin
            rd_word.ctl.cfg = cfg_q;
        end else if (coeff_hit) begin
            rd_word.coeff = coeff_q[coeff_idx];
        end
    end

    //------------------------------------------------------------
    // Registers, ack and read data
    //------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            ack_q <= 1'b0;
            rd_q  <= '0;
            cfg_q <= '0;
            for (int i = 0; i < aip_data_pkg::NUM_CHN*4; i++) begin
                coeff_q[i] <= '0;
            end
        end else begin
            ack_q <= access;
            if (access) begin
                rd_q <= rd_word;
            end
            if (access && wb_req.we) begin
                if (wb_req.adr == aip_cfg_pkg::REG_CTRL) begin
                    cfg_q <= wr_word.ctl.cfg;
                end else if (coeff_hit) begin
                    coeff_q[coeff_idx] <= wr_word.coeff;
                end
            end
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_q;
    assign cfg        = cfg_q;

    // Coefficient set of the channel under conversion
    always_comb begin
        coeff_set = '0;
        if (chn_sel < aip_data_pkg::NUM_CHN) begin
            coeff_set.ke  = coeff_q[{chn_sel, 2'd0}];
            coeff_set.b   = coeff_q[{chn_sel, 2'd1}];
            coeff_set.kqe = coeff_q[{chn_sel, 2'd2}];
            coeff_set.bq  = coeff_q[{chn_sel, 2'd3}];
        end
    end

endmodule

// ==== logic/aip_data_pkg.sv ====
// Datapath types; samples are signed integers, coefficients signed Q16.16, math wraps at 32 bits
package aip_data_pkg;

    localparam int NUM_CHN  = 6;
    localparam int FRAC_W   = 16;

    // Clock cycles per microsecond tick
    localparam int TICK_DIV = 125;

    typedef logic        [2:0]  chn_idx_t;
    typedef logic signed [15:0] sample_t;
    typedef logic signed [31:0] coeff_t;

    // Coefficient set of one channel
    typedef struct packed {
        coeff_t ke;
        coeff_t b;
        coeff_t kqe;
        coeff_t bq;
    } chn_coeff_t;

    // Engineering value of one channel
    typedef struct packed {
        logic     valid;
        chn_idx_t chn;
        coeff_t   value;
    } chn_result_t;

    // Diagnostic substitutes, b is zero
    localparam sample_t DIAG_SAMPLE = 16'sd4177;
    localparam coeff_t  DIAG_KE     = 32'sh0001_0000;    // 1.0
    localparam coeff_t  DIAG_KQE    = 32'sh0006_4000;    // 6.25
    localparam coeff_t  DIAG_BQ     = 32'shFFE7_0000;    // -25.0

    typedef enum logic [2:0] {
        S_IDLE,
        S_CHN,
        S_STEP1,
        S_STEP2,
        S_DONE
    } scan_state_t;

endpackage

// ==== logic/aip_mac_unit.sv ====
// Pipelined Q16.16 multiply-add, two cycles of latency, one new operation per cycle
`timescale 1ns/1ps

module aip_mac_unit (
    input  logic                 clk_sys,
    input  logic                 rst_sys_n,
    input  logic                 mac_start,
    input  aip_data_pkg::coeff_t mac_x,
    input  aip_data_pkg::coeff_t mac_k,
    input  aip_data_pkg::coeff_t mac_c,
    output logic                 mac_done,
    output aip_data_pkg::coeff_t mac_y
);

    logic signed [63:0]   prod_q;
    aip_data_pkg::coeff_t add_q;
    logic                 stage1_vld_q;

    //------------------------------------------------------------
    // Valid pipe
    //------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            stage1_vld_q <= 1'b0;
            mac_done     <= 1'b0;
        end else begin
            stage1_vld_q <= mac_start;
            mac_done     <= stage1_vld_q;
        end
    end

    //------------------------------------------------------------
    // Datapath
    //------------------------------------------------------------

    // Full signed product, addend travels alongside
    always_ff @(posedge clk_sys) begin
        prod_q <= mac_x * mac_k;
        add_q  <= mac_c;
    end

    // Drop the fraction of the product, add, wrap to 32 bits
    always_ff @(posedge clk_sys) begin
        mac_y <= aip_data_pkg::coeff_t'(prod_q >>> aip_data_pkg::FRAC_W) + add_q;
    end

endmodule

// ==== logic/aip_sample_bank.sv ====
// Newest sample per channel; a strobe in the same cycle as take keeps the channel fresh
`timescale 1ns/1ps

module aip_sample_bank (
    input  logic                                              clk_sys,
    input  logic                                              rst_sys_n,
    input  logic                 [aip_data_pkg::NUM_CHN-1:0]  smp_valid,
    input  aip_data_pkg::sample_t [aip_data_pkg::NUM_CHN-1:0] smp_data,
    input  aip_data_pkg::chn_idx_t                            chn_sel,
    input  logic                                              take,
    output aip_data_pkg::sample_t                             sample,
    output logic                                              fresh
);

    aip_data_pkg::sample_t            smp_q [aip_data_pkg::NUM_CHN];
    logic [aip_data_pkg::NUM_CHN-1:0] fresh_q;

    always_ff @(posedge clk_sys) begin
        for (int i = 0; i < aip_data_pkg::NUM_CHN; i++) begin
            if (smp_valid[i]) begin
                smp_q[i] <= smp_data[i];
            end
        end
    end

    // Set by a new sample, cleared once the controller consumes it
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            fresh_q <= '0;
        end else begin
            for (int i = 0; i < aip_data_pkg::NUM_CHN; i++) begin
                if (smp_valid[i]) begin
                    fresh_q[i] <= 1'b1;
                end else if (take && chn_sel == aip_data_pkg::chn_idx_t'(i)) begin
                    fresh_q[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        sample = '0;
        fresh  = 1'b0;
        if (chn_sel < aip_data_pkg::NUM_CHN) begin
            sample = smp_q[chn_sel];
            fresh  = fresh_q[chn_sel];
        end
    end

endmodule

// ==== logic/aip_scan_ctrl.sv ====
// Scan sequencer; period counts only while idle with run set, a running scan always completes
`timescale 1ns/1ps

module aip_scan_ctrl (
    input  logic                      clk_sys,
    input  logic                      rst_sys_n,
    input  aip_cfg_pkg::scan_cfg_t    cfg,
    input  aip_data_pkg::chn_coeff_t  coeff_set,
    input  aip_data_pkg::sample_t     sample,
    input  logic                      fresh,
    output aip_data_pkg::chn_idx_t    chn_sel,
    output logic                      take,
    output logic                      mac_start,
    output aip_data_pkg::coeff_t      mac_x,
    output aip_data_pkg::coeff_t      mac_k,
    output aip_data_pkg::coeff_t      mac_c,
    input  logic                      mac_done,
    input  aip_data_pkg::coeff_t      mac_y,
    output aip_data_pkg::chn_result_t result,
    output logic                      scan_done
);

    aip_data_pkg::scan_state_t state_q;
    aip_data_pkg::chn_idx_t    chn_q;
    aip_data_pkg::sample_t     smp_sel;
    aip_data_pkg::chn_idx_t    res_chn_q;
    aip_data_pkg::coeff_t      res_value_q;
    logic [$clog2(aip_data_pkg::TICK_DIV)-1:0] us_cnt_q;
    logic [11:0]               per_cnt_q;
    logic                      timing;
    logic                      us_tick;
    logic                      scan_go;
    logic                      convert;
    logic                      diag;
    logic                      last_chn;
    logic                      res_valid_q;

    //------------------------------------------------------------
    // Microsecond prescaler and period timer
    //------------------------------------------------------------
    assign timing  = cfg.run && (state_q == aip_data_pkg::S_IDLE);
    assign us_tick = (us_cnt_q == aip_data_pkg::TICK_DIV - 1);
    assign scan_go = timing && us_tick &&
                     (({1'b0, per_cnt_q} + 13'd1) >= {1'b0, cfg.period_us});

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            us_cnt_q  <= '0;
            per_cnt_q <= '0;
        end else if (!timing) begin
            us_cnt_q  <= '0;
            per_cnt_q <= '0;
        end else if (us_tick) begin
            us_cnt_q  <= '0;
            per_cnt_q <= scan_go ? 12'd0 : per_cnt_q + 12'd1;
        end else begin
            us_cnt_q  <= us_cnt_q + 1'b1;
        end
    end

    //------------------------------------------------------------
    // Channel walk
    //------------------------------------------------------------
    assign convert  = cfg.chn_enable[chn_q] && fresh;
    assign diag     = cfg.diag_mode[chn_q];
    assign last_chn = (chn_q == aip_data_pkg::chn_idx_t'(aip_data_pkg::NUM_CHN - 1));
    assign smp_sel  = diag ? aip_data_pkg::DIAG_SAMPLE : sample;
    assign chn_sel  = chn_q;
    assign take     = (state_q == aip_data_pkg::S_CHN) && convert;

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            state_q     <= aip_data_pkg::S_IDLE;
            chn_q       <= '0;
            mac_start   <= 1'b0;
            res_valid_q <= 1'b0;
            scan_done   <= 1'b0;
        end else begin
            mac_start   <= 1'b0;
            res_valid_q <= 1'b0;
            scan_done   <= 1'b0;
            case (state_q)
                aip_data_pkg::S_IDLE: begin
                    chn_q <= '0;
                    if (scan_go) begin
                        state_q <= aip_data_pkg::S_CHN;
                    end
                end
                aip_data_pkg::S_CHN: begin
                    if (convert) begin
                        mac_start <= 1'b1;
                        state_q   <= aip_data_pkg::S_STEP1;
                    end else if (last_chn) begin
                        state_q <= aip_data_pkg::S_DONE;
                    end else begin
                        chn_q <= chn_q + 1'b1;
                    end
                end
                aip_data_pkg::S_STEP1: begin
                    if (mac_done) begin
                        mac_start <= 1'b1;
                        state_q   <= aip_data_pkg::S_STEP2;
                    end
                end
                aip_data_pkg::S_STEP2: begin
                    if (mac_done) begin
                        res_valid_q <= 1'b1;
                        if (last_chn) begin
                            state_q <= aip_data_pkg::S_DONE;
                        end else begin
                            chn_q   <= chn_q + 1'b1;
                            state_q <= aip_data_pkg::S_CHN;
                        end
                    end
                end
                // Extra cycle keeps scan_done clear of the last result
                aip_data_pkg::S_DONE: begin
                    scan_done <= 1'b1;
                    state_q   <= aip_data_pkg::S_IDLE;
                end
                default: begin
                    state_q <= aip_data_pkg::S_IDLE;
                end
            endcase
        end
    end

    //------------------------------------------------------------
    // Operands and result
    //------------------------------------------------------------
    always_ff @(posedge clk_sys) begin
        if (state_q == aip_data_pkg::S_CHN && convert) begin
            // Sample as a Q16.16 integer
            mac_x <= aip_data_pkg::coeff_t'(smp_sel) << aip_data_pkg::FRAC_W;
            mac_k <= diag ? aip_data_pkg::DIAG_KE : coeff_set.ke;
            mac_c <= diag ? '0 : coeff_set.b;
        end else if (state_q == aip_data_pkg::S_STEP1 && mac_done) begin
            mac_x <= mac_y;
            mac_k <= diag ? aip_data_pkg::DIAG_KQE : coeff_set.kqe;
            mac_c <= diag ? aip_data_pkg::DIAG_BQ : coeff_set.bq;
        end
        if (state_q == aip_data_pkg::S_STEP2 && mac_done) begin
            res_chn_q   <= chn_q;
            res_value_q <= mac_y;
        end
    end

    assign result.valid = res_valid_q;
    assign result.chn   = res_chn_q;
    assign result.value = res_value_q;

endmodule

// ==== logic/aip_top.sv ====
// Six-channel scan top; results leave in ascending channel order, scan_done closes each scan
`timescale 1ns/1ps

module aip_top (
    input  logic                                              clk_sys,
    input  logic                                              rst_sys_n,
    input  aip_cfg_pkg::wb_req_t                              wb_req,
    output aip_cfg_pkg::wb_rsp_t                              wb_rsp,
    input  logic                 [aip_data_pkg::NUM_CHN-1:0]  smp_valid,
    input  aip_data_pkg::sample_t [aip_data_pkg::NUM_CHN-1:0] smp_data,
    output aip_data_pkg::chn_result_t                         result,
    output logic                                              scan_done
);

    aip_cfg_pkg::scan_cfg_t   cfg;
    aip_data_pkg::chn_coeff_t coeff_set;
    aip_data_pkg::chn_idx_t   chn_sel;
    aip_data_pkg::sample_t    sample;
    aip_data_pkg::coeff_t     mac_x;
    aip_data_pkg::coeff_t     mac_k;
    aip_data_pkg::coeff_t     mac_c;
    aip_data_pkg::coeff_t     mac_y;
    logic                     fresh;
    logic                     take;
    logic                     mac_start;
    logic                     mac_done;

    aip_coeff_regs u_coeff_regs (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .chn_sel   (chn_sel),
        .cfg       (cfg),
        .coeff_set (coeff_set)
    );

    aip_sample_bank u_sample_bank (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .smp_valid (smp_valid),
        .smp_data  (smp_data),
        .chn_sel   (chn_sel),
        .take      (take),
        .sample    (sample),
        .fresh     (fresh)
    );

    aip_scan_ctrl u_scan_ctrl (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .cfg       (cfg),
        .coeff_set (coeff_set),
        .sample    (sample),
        .fresh     (fresh),
        .chn_sel   (chn_sel),
        .take      (take),
        .mac_start (mac_start),
        .mac_x     (mac_x),
        .mac_k     (mac_k),
        .mac_c     (mac_c),
        .mac_done  (mac_done),
        .mac_y     (mac_y),
        .result    (result),
        .scan_done (scan_done)
    );

    aip_mac_unit u_mac_unit (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .mac_start (mac_start),
        .mac_x     (mac_x),
        .mac_k     (mac_k),
        .mac_c     (mac_c),
        .mac_done  (mac_done),
        .mac_y     (mac_y)
    );

endmodule

// ==== testbench/aip_chk.sv ====
// Bound into aip_top; properties sample on the rising clock and are off during reset
`timescale 1ns/1ps

module aip_chk (
    input logic                      clk_sys,
    input logic                      rst_sys_n,
    input aip_cfg_pkg::wb_req_t      wb_req,
    input aip_cfg_pkg::wb_rsp_t      wb_rsp,
    input aip_data_pkg::chn_result_t result,
    input logic                      scan_done
);

    int fail_cnt = 0;

    // Ack only inside an active bus cycle
    a_ack_in_cycle: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else begin
            fail_cnt++;
            $error("ack high outside an active Wishbone cycle");
        end

    a_valid_pulse: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        result.valid |=> !result.valid)
        else begin
            fail_cnt++;
            $error("result.valid held high for two cycles");
        end

    a_done_apart: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        !($rose(scan_done) && $rose(result.valid)))
        else begin
            fail_cnt++;
            $error("scan_done and result.valid rose together");
        end

endmodule

bind aip_top aip_chk u_chk (
    .clk_sys   (clk_sys),
    .rst_sys_n (rst_sys_n),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .result    (result),
    .scan_done (scan_done)
);

// ==== testbench/aip_tb.sv ====
// Run from the project root so testbench/aip_vectors.txt is found; stops at the first mismatch
`timescale 1ns/1ps

module aip_tb;

    localparam int    MAX_PERIOD_US = 4095;
    localparam string VEC_FILE      = "testbench/aip_vectors.txt";

    logic                                             clk_sys;
    logic                                             rst_sys_n;
    aip_cfg_pkg::wb_req_t                             wb_req;
    aip_cfg_pkg::wb_rsp_t                             wb_rsp;
    logic                 [aip_data_pkg::NUM_CHN-1:0] smp_valid;
    aip_data_pkg::sample_t [aip_data_pkg::NUM_CHN-1:0] smp_data;
    aip_data_pkg::chn_result_t                        result;
    logic                                             scan_done;

    aip_data_pkg::chn_result_t res_q [$];
    int                        done_cnt  = 0;
    int                        done_seen = 0;
    int                        n_rec     = 0;
    int unsigned               rnd;
    logic [8*24-1:0]           test_name;

    aip_top dut (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .smp_valid (smp_valid),
        .smp_data  (smp_data),
        .result    (result),
        .scan_done (scan_done)
    );

    always #4 clk_sys = ~clk_sys;

    // Outputs collected on the falling edge
    always @(negedge clk_sys) begin
        if (rst_sys_n) begin
            if (result.valid) begin
                res_q.push_back(result);
            end
            if (scan_done) begin
                done_cnt++;
            end
        end
    end

    //------------------------------------------------------------
    // Failure and compare tasks
    //------------------------------------------------------------
    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input aip_cfg_pkg::reg_word_u exp_w,
                              input aip_cfg_pkg::reg_word_u act_w);
        if (act_w !== exp_w) begin
            $display("Error: %0s expected %h actual %h", test_name, exp_w, act_w);
            abort_run();
        end
    endtask

    task automatic check_result(input aip_data_pkg::chn_result_t exp_r,
                                input aip_data_pkg::chn_result_t act_r);
        if (act_r !== exp_r) begin
            $display("Error: %0s expected chn %0d value %h actual chn %0d value %h",
                     test_name, exp_r.chn, exp_r.value, act_r.chn, act_r.value);
            abort_run();
        end
    endtask

    //------------------------------------------------------------
    // Bus, sample and result tasks
    //------------------------------------------------------------
    task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             output logic [31:0] rd);
        int gap;
        gap = $urandom % 4;
        repeat (gap + 1) @(posedge clk_sys);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr[aip_cfg_pkg::ADDR_W-1:0];
        wb_req.dat = dat;
        @(negedge clk_sys);
        while (!wb_rsp.ack) @(negedge clk_sys);
        rd = wb_rsp.dat;
        @(posedge clk_sys);
        #1;
        wb_req = '0;
    endtask

    task automatic load_sample(input int chn, input logic [15:0] val);
        @(posedge clk_sys);
        #1;
        smp_valid[chn] = 1'b1;
        smp_data[chn]  = val;
        @(posedge clk_sys);
        #1;
        smp_valid = '0;
    endtask

    task automatic expect_result(input int chn, input logic [31:0] val);
        aip_data_pkg::chn_result_t exp_r;
        aip_data_pkg::chn_result_t act_r;
        exp_r.valid = 1'b1;
        exp_r.chn   = chn[2:0];
        exp_r.value = val;
        while (res_q.size() == 0) @(negedge clk_sys);
        act_r = res_q.pop_front();
        check_result(exp_r, act_r);
    endtask

    // Every result of the scan must already be consumed by E records
    task automatic wait_scan_done();
        while (done_cnt == done_seen) @(negedge clk_sys);
        done_seen = done_cnt;
        if (res_q.size() != 0) begin
            $display("In %0s a result arrived that no record expected", test_name);
            abort_run();
        end
    endtask

    task automatic check_idle(input int cycles);
        int start_done;
        int start_res;
        start_done = done_cnt;
        start_res  = res_q.size();
        repeat (cycles) @(posedge clk_sys);
        if (done_cnt != start_done || res_q.size() != start_res) begin
            $display("In %0s a result or scan_done appeared while idle", test_name);
            abort_run();
        end
    endtask

    task automatic count_records(output int cnt);
        int              fd;
        int              n;
        logic [7:0]      tag;
        logic [8*120-1:0] rest;
        cnt = 0;
        fd  = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Vector file %0s could not be opened", VEC_FILE);
            abort_run();
        end
        n = $fscanf(fd, " %c", tag);
        while (n == 1) begin
            if (tag != "#") begin
                cnt++;
            end
            n = $fgets(rest, fd);
            n = $fscanf(fd, " %c", tag);
        end
        $fclose(fd);
    endtask

    //------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------
    initial begin
        int              fd;
        int              n;
        int              a;
        int              cnt;
        logic [7:0]      tag;
        logic [31:0]     f0;
        logic [31:0]     f1;
        logic [31:0]     rd;
        logic [8*120-1:0] rest;
        rnd       = $urandom(56192);
        clk_sys   = 1'b0;
        rst_sys_n = 1'b0;
        wb_req    = '0;
        smp_valid = '0;
        smp_data  = '0;
        test_name = "reset";
        count_records(cnt);
        n_rec = cnt;
        repeat (5) @(posedge clk_sys);
        #1;
        rst_sys_n = 1'b1;

        fd = $fopen(VEC_FILE, "r");
        n  = $fscanf(fd, " %c", tag);
        while (n == 1) begin
            case (tag)
                "#": n = $fgets(rest, fd);
                "T": n = $fscanf(fd, " %s", test_name);
                "W": begin
                    n = $fscanf(fd, " %h %h", f0, f1);
                    wb_access(1'b1, f0, f1, rd);
                end
                "R": begin
                    n = $fscanf(fd, " %h %h", f0, f1);
                    wb_access(1'b0, f0, 32'd0, rd);
                    check_word(f1, rd);
                end
                "Z": begin
                    n = $fscanf(fd, " %h %h", f0, f1);
                    for (a = f0; a <= f1; a++) begin
                        wb_access(1'b0, a, 32'd0, rd);
                        check_word(32'd0, rd);
                    end
                end
                "S": begin
                    n = $fscanf(fd, " %h %h", f0, f1);
                    load_sample(f0, f1[15:0]);
                end
                "E": begin
                    n = $fscanf(fd, " %h %h", f0, f1);
                    expect_result(f0, f1);
                end
                "D": wait_scan_done();
                "Q": begin
                    n = $fscanf(fd, " %h", f0);
                    check_idle(f0);
                end
                default: begin
                    $display("Unknown record tag %c in the vector file", tag);
                    abort_run();
                end
            endcase
            n = $fscanf(fd, " %c", tag);
        end
        $fclose(fd);

        if (dut.u_chk.fail_cnt == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "Bound assertions reported failures");
        end
    end

    // Watchdog sized for the longest scan period on every record
    initial begin
        wait (n_rec > 0);
        repeat (n_rec * (MAX_PERIOD_US * aip_data_pkg::TICK_DIV + 200)) @(posedge clk_sys);
        $display("Watchdog expired, the DUT stopped responding and the run hung");
        $display("Test failed");
        $fatal(1);
    end

endmodule

// ==== testbench/aip_vectors.txt ====
# Tag then hex fields: T name | W adr data | R adr expected | Z first last (all read zero)
# S chn sample | E chn value (next result) | D (scan_done, nothing extra) | Q cycles idle
T reset
Z 00 1F
Q 190
T readback
W 08 00020000
W 09 00008000
W 0A 00018000
W 0B FFFF0000
W 00 00123A95
R 08 00020000
R 09 00008000
R 0A 00018000
R 0B FFFF0000
R 00 00123A95
T convert
W 10 00004000
W 11 FFFE0000
W 12 FFFF8000
W 13 000A0000
W 18 00030000
S 0 0064
S 2 FF38
S 3 0555
S 4 1234
W 00 01002417
E 0 012BC000
E 2 00240000
E 4 65E14000
D
W 00 00002417
T stale
S 2 0064
W 00 01002417
E 2 FFFE8000
D
W 00 00000000
R 00 00000000
Q 190
